//--- common/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

`define XLEN 64
`define ILEN 32

// Major opcodes, instr[6:0]
`define OPC_REG      7'b0110011
`define OPC_REG_W    7'b0111011
`define OPC_IMM      7'b0010011
`define OPC_IMM_W    7'b0011011
`define OPC_LOAD     7'b0000011
`define OPC_JALR     7'b1100111
`define OPC_STORE    7'b0100011
`define OPC_BRANCH   7'b1100011
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111
`define OPC_JAL      7'b1101111
`define OPC_FENCE    7'b0001111
`define OPC_SYSTEM   7'b1110011

// Exception cause codes
`define EXC_ILLEGAL  4'd2
`define EXC_BREAK    4'd3
`define EXC_ECALL_U  4'd8
`define EXC_ECALL_S  4'd9
`define EXC_ECALL_M  4'd11

`define SYS_MRET     12'b0011_0000_0010  // funct12 of mret

`endif

//--- common/rv_decode_pkg.sv
`include "rv_decode_config.svh"

package rv_decode_pkg;

    // ALU operation codes as seen by the execute stage
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd5,
        ALU_NOP  = 4'd10,
        ALU_SLT  = 4'd11,
        ALU_SLTU = 4'd12,
        ALU_SLL  = 4'd13,
        ALU_SRL  = 4'd14,
        ALU_SRA  = 4'd15
    } alu_op_e;

    // Control bundle handed to execute
    typedef struct packed {
        logic [4:0] w_regs_addr;       // Destination register
        logic       we_regs;           // Register file write
        logic       we_dmem;           // Data memory write
        logic [7:0] dmem_byte_en;      // Byte lanes for load/store
        logic       operand_b_is_imm;  // ALU B from immediate
        logic       is_jal;
        logic       is_jalr;
        logic       is_load;
        logic       is_auipc;
        logic       is_32bit;          // W-suffix operation
        alu_op_e    alu_op;
    } dec_ctrl_t;

    typedef struct packed {
        logic              taken;
        logic [`XLEN-1:0]  target;
    } branch_t;

    typedef struct packed {
        logic              exc_en;
        logic [3:0]        exc_code;
        logic [`XLEN-1:0]  exc_val;
        logic              mret;
    } trap_t;

endpackage

//--- decoder/instr_field_decoder.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module instr_field_decoder (
    input  logic [`ILEN-1:0]        instr,
    output rv_decode_pkg::dec_ctrl_t ctrl,
    output logic [`XLEN-1:0]        imm,
    output logic [2:0]              funct3,
    output logic [4:0]              rs1_addr,
    output logic [4:0]              rs2_addr,
    output logic                    is_branch,
    output logic                    is_system,
    output logic                    illegal
);

    logic [7:0]       mem_be;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_j = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // Access width from funct3, unsigned variants not enabled
    always_comb begin
        case (instr[14:12])
            3'b000:  mem_be = 8'b0000_0001;  // Byte
            3'b001:  mem_be = 8'b0000_0011;  // Half
            3'b010:  mem_be = 8'b0000_1111;  // Word
            3'b011:  mem_be = 8'b1111_1111;  // Double
            default: mem_be = 8'b0000_0000;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = rv_decode_pkg::ALU_NOP;  // Filled in by the ALU decoder
        imm         = '0;
        funct3      = 3'b000;
        rs1_addr    = 5'd0;
        rs2_addr    = 5'd0;
        is_branch   = 1'b0;
        is_system   = 1'b0;
        illegal     = 1'b0;

        case (instr[6:0])
            `OPC_REG, `OPC_REG_W: begin
                funct3           = instr[14:12];
                rs1_addr         = instr[19:15];
                rs2_addr         = instr[24:20];
                ctrl.w_regs_addr = instr[11:7];
                ctrl.we_regs     = 1'b1;
                ctrl.is_32bit    = (instr[6:0] == `OPC_REG_W);
            end
            `OPC_IMM, `OPC_IMM_W: begin
                funct3                = instr[14:12];
                rs1_addr              = instr[19:15];
                ctrl.w_regs_addr      = instr[11:7];
                imm                   = imm_i;
                ctrl.we_regs          = 1'b1;
                ctrl.operand_b_is_imm = 1'b1;
                ctrl.is_32bit         = (instr[6:0] == `OPC_IMM_W);
            end
            `OPC_LOAD: begin
                funct3                = instr[14:12];
                rs1_addr              = instr[19:15];
                ctrl.w_regs_addr      = instr[11:7];
                imm                   = imm_i;
                ctrl.we_regs          = 1'b1;
                ctrl.operand_b_is_imm = 1'b1;
                ctrl.is_load          = 1'b1;
                ctrl.dmem_byte_en     = mem_be;
            end
            `OPC_JALR: begin
                funct3                = instr[14:12];
                rs1_addr              = instr[19:15];
                ctrl.w_regs_addr      = instr[11:7];
                imm                   = imm_i;
                ctrl.we_regs          = 1'b1;
                ctrl.operand_b_is_imm = 1'b1;
                ctrl.is_jalr          = 1'b1;
            end
            `OPC_STORE: begin
                funct3                = instr[14:12];
                rs1_addr              = instr[19:15];
                rs2_addr              = instr[24:20];
                imm                   = imm_s;
                ctrl.we_dmem          = 1'b1;
                ctrl.operand_b_is_imm = 1'b1;
                ctrl.dmem_byte_en     = mem_be;
            end
            `OPC_BRANCH: begin
                funct3                = instr[14:12];
                rs1_addr              = instr[19:15];
                rs2_addr              = instr[24:20];
                imm                   = imm_b;
                ctrl.operand_b_is_imm = 1'b1;
                is_branch             = 1'b1;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                ctrl.w_regs_addr      = instr[11:7];
                imm                   = imm_u;
                ctrl.we_regs          = 1'b1;
                ctrl.operand_b_is_imm = 1'b1;
                ctrl.is_auipc         = (instr[6:0] == `OPC_AUIPC);
            end
            `OPC_JAL: begin
                ctrl.w_regs_addr      = instr[11:7];
                imm                   = imm_j;
                ctrl.we_regs          = 1'b1;
                ctrl.operand_b_is_imm = 1'b1;
                ctrl.is_jal           = 1'b1;
            end
            `OPC_SYSTEM: begin
                funct3    = instr[14:12];  // Checked by the system decoder
                is_system = 1'b1;
            end
            `OPC_FENCE: begin
                // Single hart with in-order memory, nothing to order
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

//--- decoder/alu_op_decoder.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module alu_op_decoder (
    input  logic [`ILEN-1:0]       instr,
    output rv_decode_pkg::alu_op_e alu_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        alu_op = rv_decode_pkg::ALU_NOP;
        case (opcode)
            `OPC_REG: begin
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = rv_decode_pkg::ALU_ADD;
                    10'b0100000_000: alu_op = rv_decode_pkg::ALU_SUB;
                    10'b0000000_001: alu_op = rv_decode_pkg::ALU_SLL;
                    10'b0000000_010: alu_op = rv_decode_pkg::ALU_SLT;
                    10'b0000000_011: alu_op = rv_decode_pkg::ALU_SLTU;
                    10'b0000000_100: alu_op = rv_decode_pkg::ALU_XOR;
                    10'b0000000_101: alu_op = rv_decode_pkg::ALU_SRL;
                    10'b0100000_101: alu_op = rv_decode_pkg::ALU_SRA;
                    10'b0000000_110: alu_op = rv_decode_pkg::ALU_OR;
                    10'b0000000_111: alu_op = rv_decode_pkg::ALU_AND;
                    default:         alu_op = rv_decode_pkg::ALU_NOP;
                endcase
            end
            `OPC_REG_W: begin
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = rv_decode_pkg::ALU_ADD;  // ADDW
                    10'b0100000_000: alu_op = rv_decode_pkg::ALU_SUB;  // SUBW
                    10'b0000000_001: alu_op = rv_decode_pkg::ALU_SLL;
                    10'b0000000_101: alu_op = rv_decode_pkg::ALU_SRL;
                    10'b0100000_101: alu_op = rv_decode_pkg::ALU_SRA;
                    default:         alu_op = rv_decode_pkg::ALU_NOP;
                endcase
            end
            `OPC_IMM: begin
                case (funct3)
                    3'b000: alu_op = rv_decode_pkg::ALU_ADD;
                    3'b001: alu_op = rv_decode_pkg::ALU_SLL;
                    3'b010: alu_op = rv_decode_pkg::ALU_SLT;
                    3'b011: alu_op = rv_decode_pkg::ALU_SLTU;
                    3'b100: alu_op = rv_decode_pkg::ALU_XOR;
                    3'b110: alu_op = rv_decode_pkg::ALU_OR;
                    3'b111: alu_op = rv_decode_pkg::ALU_AND;
                    default: begin
                        // RV64 shamt is 6 bits, so bit 25 belongs to it
                        if (funct7[6:1] == 6'b000000) begin
                            alu_op = rv_decode_pkg::ALU_SRL;
                        end else if (funct7[6:1] == 6'b010000) begin
                            alu_op = rv_decode_pkg::ALU_SRA;
                        end
                    end
                endcase
            end
            `OPC_IMM_W: begin
                case (funct3)
                    3'b000: alu_op = rv_decode_pkg::ALU_ADD;  // ADDIW
                    3'b001: alu_op = rv_decode_pkg::ALU_SLL;
                    3'b101: begin
                        if (funct7 == 7'b0000000) begin
                            alu_op = rv_decode_pkg::ALU_SRL;
                        end else if (funct7 == 7'b0100000) begin
                            alu_op = rv_decode_pkg::ALU_SRA;
                        end
                    end
                    default: alu_op = rv_decode_pkg::ALU_NOP;
                endcase
            end
            `OPC_LOAD, `OPC_STORE, `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR: begin
                alu_op = rv_decode_pkg::ALU_ADD;  // Address or link arithmetic
            end
            default: alu_op = rv_decode_pkg::ALU_NOP;
        endcase
    end

endmodule

//--- source/branch_unit.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module branch_unit (
    input  logic [`XLEN-1:0]       regs_data1,
    input  logic [`XLEN-1:0]       regs_data2,
    input  logic [`XLEN-1:0]       pc_addr,
    input  logic [`XLEN-1:0]       imm,
    input  logic [2:0]             funct3,
    input  logic                   is_branch,
    input  logic                   is_jal,
    input  logic                   is_jalr,
    output rv_decode_pkg::branch_t branch
);

    logic cond;

    always_comb begin
        case (funct3)
            3'b000:  cond = (regs_data1 == regs_data2);                   // BEQ
            3'b001:  cond = (regs_data1 != regs_data2);                   // BNE
            3'b100:  cond = ($signed(regs_data1) <  $signed(regs_data2)); // BLT
            3'b101:  cond = ($signed(regs_data1) >= $signed(regs_data2)); // BGE
            3'b110:  cond = (regs_data1 <  regs_data2);                   // BLTU
            3'b111:  cond = (regs_data1 >= regs_data2);                   // BGEU
            default: cond = 1'b0;
        endcase
    end

    assign branch.taken = is_jal | is_jalr | (is_branch & cond);

    // jalr is register relative with the LSB dropped
    assign branch.target = is_jalr ? ((regs_data1 + imm) & ~`XLEN'd1)
                                   : (pc_addr + imm);

endmodule

//--- source/system_decoder.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module system_decoder (
    input  logic [`ILEN-1:0]     instr,
    input  logic                 is_system,
    input  logic                 illegal,
    input  logic [1:0]           priv_lvl,
    output rv_decode_pkg::trap_t trap
);

    logic [11:0] funct12;
    logic        bad_instr;

    assign funct12 = instr[31:20];

    always_comb begin
        trap      = '0;
        bad_instr = illegal;

        if (is_system) begin
            if (instr[14:12] != 3'b000) begin
                bad_instr = 1'b1;  // CSR instructions not supported
            end else if (funct12 == 12'h000) begin
                trap.exc_en = 1'b1;  // ECALL
                case (priv_lvl)
                    2'b11:   trap.exc_code = `EXC_ECALL_M;
                    2'b01:   trap.exc_code = `EXC_ECALL_S;
                    default: trap.exc_code = `EXC_ECALL_U;
                endcase
            end else if (funct12 == 12'h001) begin
                trap.exc_en   = 1'b1;  // EBREAK
                trap.exc_code = `EXC_BREAK;
            end else if (funct12 == `SYS_MRET) begin
                trap.mret = 1'b1;
            end else begin
                bad_instr = 1'b1;
            end
        end

        if (bad_instr) begin
            trap.exc_en   = 1'b1;
            trap.exc_code = `EXC_ILLEGAL;
            trap.exc_val  = {{(`XLEN-`ILEN){1'b0}}, instr};  // Faulting encoding
        end
    end

endmodule

//--- source/rv_decode_stage.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module rv_decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     instr_valid,
    input  logic                     trap_taken,
    input  logic                     trap_done,
    input  logic [`ILEN-1:0]         instr,
    input  logic [`XLEN-1:0]         regs_data1,
    input  logic [`XLEN-1:0]         regs_data2,
    input  logic [`XLEN-1:0]         pc_addr,
    input  logic [1:0]               priv_lvl,
    output logic [4:0]               r_regs_addr1,
    output logic [4:0]               r_regs_addr2,
    output logic                     ex_valid,
    output rv_decode_pkg::dec_ctrl_t ex_ctrl,
    output logic [`XLEN-1:0]         ex_operand_b,
    output rv_decode_pkg::branch_t   ex_branch,
    output rv_decode_pkg::trap_t     ex_trap
);

    rv_decode_pkg::dec_ctrl_t fd_ctrl;
    rv_decode_pkg::dec_ctrl_t dec_ctrl;
    rv_decode_pkg::alu_op_e   alu_op;
    rv_decode_pkg::branch_t   branch;
    rv_decode_pkg::branch_t   dec_branch;
    rv_decode_pkg::trap_t     trap;
    rv_decode_pkg::trap_t     dec_trap;
    logic [`XLEN-1:0]         imm;
    logic [`XLEN-1:0]         operand_b;
    logic [2:0]               funct3;
    logic                     is_branch;
    logic                     is_system;
    logic                     illegal;

    instr_field_decoder field_dec_i (
        .instr     (instr),
        .ctrl      (fd_ctrl),
        .imm       (imm),
        .funct3    (funct3),
        .rs1_addr  (r_regs_addr1),
        .rs2_addr  (r_regs_addr2),
        .is_branch (is_branch),
        .is_system (is_system),
        .illegal   (illegal)
    );

    alu_op_decoder alu_dec_i (
        .instr  (instr),
        .alu_op (alu_op)
    );

    branch_unit branch_i (
        .regs_data1 (regs_data1),
        .regs_data2 (regs_data2),
        .pc_addr    (pc_addr),
        .imm        (imm),
        .funct3     (funct3),
        .is_branch  (is_branch),
        .is_jal     (fd_ctrl.is_jal),
        .is_jalr    (fd_ctrl.is_jalr),
        .branch     (branch)
    );

    system_decoder sys_dec_i (
        .instr     (instr),
        .is_system (is_system),
        .illegal   (illegal),
        .priv_lvl  (priv_lvl),
        .trap      (trap)
    );

    // Trap entry or exit blanks the decode
    always_comb begin
        dec_ctrl        = fd_ctrl;
        dec_ctrl.alu_op = alu_op;
        dec_branch      = branch;
        dec_trap        = trap;
        if (trap_taken || trap_done) begin
            dec_ctrl        = '0;
            dec_ctrl.alu_op = rv_decode_pkg::ALU_NOP;
            dec_branch      = '0;
            dec_trap        = '0;
        end
    end

    assign operand_b = dec_ctrl.operand_b_is_imm ? imm : regs_data2;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_ctrl      <= '0;
            ex_operand_b <= '0;
            ex_branch    <= '0;
            ex_trap      <= '0;
        end else begin
            ex_valid     <= instr_valid;
            ex_ctrl      <= instr_valid ? dec_ctrl : '0;  // Bubble when idle
            ex_operand_b <= instr_valid ? operand_b : '0;
            ex_branch    <= instr_valid ? dec_branch : '0;
            ex_trap      <= instr_valid ? dec_trap : '0;
        end
    end

endmodule

//--- testbench/rv_decode_stage_properties.sv
`timescale 1ns/1ps

module rv_decode_stage_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     ex_valid,
    input rv_decode_pkg::dec_ctrl_t ex_ctrl,
    input rv_decode_pkg::branch_t   ex_branch,
    input rv_decode_pkg::trap_t     ex_trap
);

    int unsigned fail_count = 0;  // Failed assertions so far

    valid_low_after_reset: assert property (
        @(posedge clk) !rst_n |=> !ex_valid
    ) else begin
        fail_count++;
        $error("ex_valid high in the cycle after reset");
    end

    // A trapping instruction must not change architectural state
    trap_blocks_writes: assert property (
        @(posedge clk) disable iff (!rst_n)
        ex_trap.exc_en |-> !(ex_ctrl.we_regs || ex_ctrl.we_dmem)
    ) else begin
        fail_count++;
        $error("register or memory write alongside a trap request");
    end

    jalr_target_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ex_branch.taken && ex_ctrl.is_jalr) |-> !ex_branch.target[0]
    ) else begin
        fail_count++;
        $error("taken jalr target has bit 0 set");
    end

endmodule

bind rv_decode_stage rv_decode_stage_properties props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ex_valid  (ex_valid),
    .ex_ctrl   (ex_ctrl),
    .ex_branch (ex_branch),
    .ex_trap   (ex_trap)
);

//--- testbench/rv_decode_stage_tb.sv
`timescale 1ns/1ps
`include "rv_decode_config.svh"

module rv_decode_stage_tb;

    localparam int  NUM_VECTORS  = 3000;
    localparam int  RESET_CYCLES = 8;
    localparam time CLK_PERIOD   = 40;
    localparam time TIMEOUT      = (NUM_VECTORS + RESET_CYCLES + 4) * CLK_PERIOD;

    logic                     clk;
    logic                     rst_n;
    logic                     instr_valid;
    logic                     trap_taken;
    logic                     trap_done;
    logic [`ILEN-1:0]         instr;
    logic [`XLEN-1:0]         regs_data1;
    logic [`XLEN-1:0]         regs_data2;
    logic [`XLEN-1:0]         pc_addr;
    logic [1:0]               priv_lvl;
    logic [4:0]               r_regs_addr1;
    logic [4:0]               r_regs_addr2;
    logic                     ex_valid;
    rv_decode_pkg::dec_ctrl_t ex_ctrl;
    logic [`XLEN-1:0]         ex_operand_b;
    rv_decode_pkg::branch_t   ex_branch;
    rv_decode_pkg::trap_t     ex_trap;

    // Model outputs, compared one cycle after they are computed
    logic                     exp_valid;
    rv_decode_pkg::dec_ctrl_t exp_ctrl;
    logic [`XLEN-1:0]         exp_opb;
    rv_decode_pkg::branch_t   exp_branch;
    rv_decode_pkg::trap_t     exp_trap;
    logic [4:0]               exp_rs1;
    logic [4:0]               exp_rs2;

    logic [31:0] lfsr_state;

    rv_decode_stage dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .trap_taken   (trap_taken),
        .trap_done    (trap_done),
        .instr        (instr),
        .regs_data1   (regs_data1),
        .regs_data2   (regs_data2),
        .pc_addr      (pc_addr),
        .priv_lvl     (priv_lvl),
        .r_regs_addr1 (r_regs_addr1),
        .r_regs_addr2 (r_regs_addr2),
        .ex_valid     (ex_valid),
        .ex_ctrl      (ex_ctrl),
        .ex_operand_b (ex_operand_b),
        .ex_branch    (ex_branch),
        .ex_trap      (ex_trap)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT);
        $display("TIMEOUT: stimulus did not complete within %0t", TIMEOUT);
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired");
    end

    always @(dut_i.props_i.fail_count) begin
        if (dut_i.props_i.fail_count != 0) begin
            $display(">>> FAIL");
            $fatal(1, "Assertion failed in the bound property checker");
        end
    end

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[62:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s actual=%h expected=%h",
                     $time, name, actual, expected);
            $display(">>> FAIL");
            $fatal(1, "Output check failed");
        end
    endtask

    function automatic rv_decode_pkg::alu_op_e expected_alu_op(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            `OPC_REG: begin
                if (f7 == 7'b0000000) begin
                    case (f3)
                        3'd0: return rv_decode_pkg::ALU_ADD;
                        3'd1: return rv_decode_pkg::ALU_SLL;
                        3'd2: return rv_decode_pkg::ALU_SLT;
                        3'd3: return rv_decode_pkg::ALU_SLTU;
                        3'd4: return rv_decode_pkg::ALU_XOR;
                        3'd5: return rv_decode_pkg::ALU_SRL;
                        3'd6: return rv_decode_pkg::ALU_OR;
                        default: return rv_decode_pkg::ALU_AND;
                    endcase
                end
                if (f7 == 7'b0100000 && f3 == 3'd0) return rv_decode_pkg::ALU_SUB;
                if (f7 == 7'b0100000 && f3 == 3'd5) return rv_decode_pkg::ALU_SRA;
            end
            `OPC_REG_W: begin
                if (f7 == 7'b0000000 && f3 == 3'd0) return rv_decode_pkg::ALU_ADD;
                if (f7 == 7'b0000000 && f3 == 3'd1) return rv_decode_pkg::ALU_SLL;
                if (f7 == 7'b0000000 && f3 == 3'd5) return rv_decode_pkg::ALU_SRL;
                if (f7 == 7'b0100000 && f3 == 3'd0) return rv_decode_pkg::ALU_SUB;
                if (f7 == 7'b0100000 && f3 == 3'd5) return rv_decode_pkg::ALU_SRA;
            end
            `OPC_IMM: begin
                case (f3)
                    3'd0: return rv_decode_pkg::ALU_ADD;
                    3'd1: return rv_decode_pkg::ALU_SLL;
                    3'd2: return rv_decode_pkg::ALU_SLT;
                    3'd3: return rv_decode_pkg::ALU_SLTU;
                    3'd4: return rv_decode_pkg::ALU_XOR;
                    3'd6: return rv_decode_pkg::ALU_OR;
                    3'd7: return rv_decode_pkg::ALU_AND;
                    default: begin
                        if (w[31:26] == 6'b000000) return rv_decode_pkg::ALU_SRL;
                        if (w[31:26] == 6'b010000) return rv_decode_pkg::ALU_SRA;
                    end
                endcase
            end
            `OPC_IMM_W: begin
                if (f3 == 3'd0) return rv_decode_pkg::ALU_ADD;
                if (f3 == 3'd1) return rv_decode_pkg::ALU_SLL;
                if (f3 == 3'd5 && f7 == 7'b0000000) return rv_decode_pkg::ALU_SRL;
                if (f3 == 3'd5 && f7 == 7'b0100000) return rv_decode_pkg::ALU_SRA;
            end
            `OPC_LOAD, `OPC_STORE, `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR: begin
                return rv_decode_pkg::ALU_ADD;
            end
            default: ;
        endcase
        return rv_decode_pkg::ALU_NOP;
    endfunction

    task automatic compute_expected();
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [63:0] imm;
        logic [63:0] sum;
        logic [8:0]  mask;
        logic        known;
        logic        has_rs1;
        logic        has_rs2;
        logic        has_rd;
        logic        b_imm;
        logic        cond;
        logic        bad;
        rv_decode_pkg::dec_ctrl_t c;
        rv_decode_pkg::branch_t   b;
        rv_decode_pkg::trap_t     t;

        opc   = instr[6:0];
        f3    = instr[14:12];
        imm   = '0;
        known = 1'b1;
        {has_rs1, has_rs2, has_rd, b_imm} = 4'b0000;
        case (opc)
            `OPC_REG, `OPC_REG_W: {has_rs1, has_rs2, has_rd, b_imm} = 4'b1110;
            `OPC_IMM, `OPC_IMM_W, `OPC_LOAD, `OPC_JALR: begin
                {has_rs1, has_rs2, has_rd, b_imm} = 4'b1011;
                imm = $signed({instr[31:20], 52'b0}) >>> 52;
            end
            `OPC_STORE: begin
                {has_rs1, has_rs2, has_rd, b_imm} = 4'b1101;
                imm = $signed({instr[31:25], instr[11:7], 52'b0}) >>> 52;
            end
            `OPC_BRANCH: begin
                {has_rs1, has_rs2, has_rd, b_imm} = 4'b1101;
                imm = $signed({instr[31], instr[7], instr[30:25], instr[11:8],
                               1'b0, 51'b0}) >>> 51;
            end
            `OPC_LUI, `OPC_AUIPC: begin
                {has_rs1, has_rs2, has_rd, b_imm} = 4'b0011;
                imm = $signed({instr[31:12], 12'b0, 32'b0}) >>> 32;
            end
            `OPC_JAL: begin
                {has_rs1, has_rs2, has_rd, b_imm} = 4'b0011;
                imm = $signed({instr[31], instr[19:12], instr[20], instr[30:21],
                               1'b0, 43'b0}) >>> 43;
            end
            `OPC_FENCE, `OPC_SYSTEM: ;
            default: known = 1'b0;
        endcase
        exp_rs1 = has_rs1 ? instr[19:15] : 5'd0;
        exp_rs2 = has_rs2 ? instr[24:20] : 5'd0;

        mask               = (9'd1 << (4'd1 << f3[1:0])) - 9'd1;  // 1, 2, 4 or 8 lanes
        c                  = '0;
        c.w_regs_addr      = has_rd ? instr[11:7] : 5'd0;
        c.we_regs          = has_rd;
        c.we_dmem          = (opc == `OPC_STORE);
        c.dmem_byte_en     = ((opc == `OPC_LOAD || opc == `OPC_STORE) && !f3[2]) ?
                             mask[7:0] : 8'h00;
        c.operand_b_is_imm = b_imm;
        c.is_jal           = (opc == `OPC_JAL);
        c.is_jalr          = (opc == `OPC_JALR);
        c.is_load          = (opc == `OPC_LOAD);
        c.is_auipc         = (opc == `OPC_AUIPC);
        c.is_32bit         = (opc == `OPC_REG_W || opc == `OPC_IMM_W);
        c.alu_op           = expected_alu_op(instr);

        case (f3)
            3'd0:    cond = (regs_data1 == regs_data2);
            3'd1:    cond = (regs_data1 != regs_data2);
            3'd4:    cond = ($signed(regs_data1) < $signed(regs_data2));
            3'd5:    cond = ($signed(regs_data1) >= $signed(regs_data2));
            3'd6:    cond = (regs_data1 < regs_data2);
            3'd7:    cond = (regs_data1 >= regs_data2);
            default: cond = 1'b0;
        endcase
        sum      = regs_data1 + imm;
        b.taken  = c.is_jal || c.is_jalr || (opc == `OPC_BRANCH && cond);
        b.target = c.is_jalr ? {sum[63:1], 1'b0} : (pc_addr + imm);

        t   = '0;
        bad = !known;
        if (opc == `OPC_SYSTEM) begin
            if (f3 != 3'd0) begin
                bad = 1'b1;
            end else begin
                case (instr[31:20])
                    12'h000: begin
                        t.exc_en   = 1'b1;
                        t.exc_code = (priv_lvl == 2'd3) ? `EXC_ECALL_M :
                                     (priv_lvl == 2'd1) ? `EXC_ECALL_S : `EXC_ECALL_U;
                    end
                    12'h001: begin
                        t.exc_en   = 1'b1;
                        t.exc_code = `EXC_BREAK;
                    end
                    `SYS_MRET: t.mret = 1'b1;
                    default:   bad = 1'b1;
                endcase
            end
        end
        if (bad) begin
            t.exc_en   = 1'b1;
            t.exc_code = `EXC_ILLEGAL;
            t.exc_val  = {32'b0, instr};
        end

        if (trap_taken || trap_done) begin  // Trap entry or exit blanks decode
            c        = '0;
            c.alu_op = rv_decode_pkg::ALU_NOP;
            b        = '0;
            t        = '0;
        end

        exp_valid  = instr_valid;
        exp_ctrl   = instr_valid ? c : '0;
        exp_opb    = !instr_valid ? '0 : (c.operand_b_is_imm ? imm : regs_data2);
        exp_branch = instr_valid ? b : '0;
        exp_trap   = instr_valid ? t : '0;
    endtask

    task automatic drive_random();
        logic [31:0] w;
        logic [3:0]  pick;
        w    = random_bits(32);
        pick = random_bits(4);
        case (pick)
            4'd0:  w[6:0] = `OPC_REG;
            4'd1:  w[6:0] = `OPC_REG_W;
            4'd2:  w[6:0] = `OPC_IMM;
            4'd3:  w[6:0] = `OPC_IMM_W;
            4'd4:  w[6:0] = `OPC_LOAD;
            4'd5:  w[6:0] = `OPC_JALR;
            4'd6:  w[6:0] = `OPC_STORE;
            4'd7:  w[6:0] = `OPC_BRANCH;
            4'd8:  w[6:0] = `OPC_LUI;
            4'd9:  w[6:0] = `OPC_AUIPC;
            4'd10: w[6:0] = `OPC_JAL;
            4'd11: w[6:0] = `OPC_FENCE;
            4'd12: w[6:0] = `OPC_SYSTEM;
            4'd13: w[6:0] = `OPC_BRANCH;
            4'd14: w[6:0] = `OPC_SYSTEM;
            default: ;  // Random opcode, mostly illegal
        endcase
        if (random_bits(1)) begin
            w[31:25] = random_bits(1) ? 7'b0100000 : 7'b0000000;  // Hit SUB and SRA
        end
        if (w[6:0] == `OPC_SYSTEM) begin
            case (random_bits(2))
                2'd0:    w[31:20] = 12'h000;
                2'd1:    w[31:20] = 12'h001;
                2'd2:    w[31:20] = `SYS_MRET;
                default: ;
            endcase
            if (random_bits(2) != 0) begin
                w[14:12] = 3'd0;
            end
        end
        instr       = w;
        regs_data1  = random_bits(64);
        regs_data2  = (random_bits(2) == 0) ? regs_data1 : random_bits(64);
        pc_addr     = random_bits(64);
        priv_lvl    = random_bits(2);
        instr_valid = (random_bits(3) != 0);
        trap_taken  = (random_bits(4) == 0);  // Rare pulses
        trap_done   = (random_bits(4) == 0);
    endtask

    task automatic check_outputs();
        check_value("ex_valid", ex_valid, exp_valid);
        check_value("ex_ctrl.alu_op", ex_ctrl.alu_op, exp_ctrl.alu_op);
        check_value("ex_ctrl", ex_ctrl, exp_ctrl);
        check_value("ex_operand_b", ex_operand_b, exp_opb);
        check_value("ex_branch", ex_branch, exp_branch);
        check_value("ex_trap", ex_trap, exp_trap);
    endtask

    initial begin
        lfsr_state  = 32'h3625;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        trap_taken  = 1'b0;
        trap_done   = 1'b0;
        instr       = '0;
        regs_data1  = '0;
        regs_data2  = '0;
        pc_addr     = '0;
        priv_lvl    = 2'd0;
        exp_valid   = 1'b0;
        exp_ctrl    = '0;
        exp_opb     = '0;
        exp_branch  = '0;
        exp_trap    = '0;

        repeat (RESET_CYCLES) @(negedge clk);
        check_outputs();  // Registered outputs cleared by reset
        rst_n = 1'b1;

        for (int n = 0; n < NUM_VECTORS; n++) begin
            @(negedge clk);
            check_outputs();
            drive_random();
            compute_expected();
            #1;
            check_value("r_regs_addr1", r_regs_addr1, exp_rs1);
            check_value("r_regs_addr2", r_regs_addr2, exp_rs2);
        end
        @(negedge clk);
        check_outputs();

        $display(">>> PASS");
        $finish;
    end

endmodule

//--- rv_decode_stage.f
+incdir+common
common/rv_decode_pkg.sv
decoder/instr_field_decoder.sv
decoder/alu_op_decoder.sv
source/branch_unit.sv
source/system_decoder.sv
source/rv_decode_stage.sv
testbench/rv_decode_stage_properties.sv
testbench/rv_decode_stage_tb.sv
